//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module addr_trans_tb \
		-f verilog.f -o addr_trans_sim

run: compile
	./obj_dir/addr_trans_sim

clean:
	rm -rf obj_dir

//--- logic/addr_trans_pkg.sv
package addr_trans_pkg;

  // number of TLB entries
  localparam int TLB_ENTRY_NUM = 16;

  // page size exponents
  localparam int PS_4K_VAL = 12;
  localparam int PS_4M_VAL = 22;

  // address and page field widths
  typedef logic [31:0] vaddr_t;
  // address bits 31:13, one key covers an even/odd page pair
  typedef logic [18:0] vppn_t;
  typedef logic [9:0]  asid_t;
  typedef logic [19:0] ppn_t;
  typedef logic [1:0]  mat_t;
  typedef logic [1:0]  plv_t;
  typedef logic [5:0]  ps_t;
  typedef logic [$clog2(TLB_ENTRY_NUM)-1:0] tlb_idx_t;

  localparam ps_t PS_4K = ps_t'(PS_4K_VAL);
  localparam ps_t PS_4M = ps_t'(PS_4M_VAL);

  // crmd fields, two-bit fields given by their low bit
  localparam int CRMD_PLV_LO  = 0;
  localparam int CRMD_DA      = 3;
  localparam int CRMD_PG      = 4;
  localparam int CRMD_DATF_LO = 5;
  localparam int CRMD_DATM_LO = 7;

  // direct map window fields
  localparam int DMW_PLV0    = 0;
  localparam int DMW_PLV3    = 3;
  localparam int DMW_MAT_LO  = 4;
  // three-bit segments
  localparam int DMW_PSEG_LO = 25;
  localparam int DMW_VSEG_LO = 29;

  // fill handshake states
  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    ACK
  } fill_state_t;

endpackage

//--- logic/addr_trans_top.sv
module addr_trans_top
  import addr_trans_pkg::*;
#(
  parameter bit FETCH_ADDR = 1'b0
) (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        fill_req_i,
  input  tlb_idx_t    fill_idx_i,
  input  vppn_t       fill_vppn_i,
  input  asid_t       fill_asid_i,
  input  logic        fill_g_i,
  input  logic        fill_huge_i,
  input  logic        fill_e_i,
  input  ppn_t        fill_ppn_i [2],
  input  logic        fill_v_i   [2],
  input  logic        fill_d_i   [2],
  input  mat_t        fill_mat_i [2],
  input  plv_t        fill_plv_i [2],
  output logic        fill_ack_o,
  input  logic        lookup_en_i,
  input  vaddr_t      vaddr_i,
  input  asid_t       asid_i,
  input  logic [31:0] crmd_i,
  input  logic [31:0] dmw0_i,
  input  logic [31:0] dmw1_i,
  output logic        found_o,
  output logic        dmw_o,
  output tlb_idx_t    index_o,
  output ps_t         ps_o,
  output ppn_t        ppn_o,
  output logic        v_o,
  output logic        d_o,
  output mat_t        mat_o,
  output plv_t        plv_o
);

  // write broadcast to all entries
  logic [TLB_ENTRY_NUM-1:0] we;
  vppn_t w_vppn;
  asid_t w_asid;
  logic  w_g;
  logic  w_huge;
  logic  w_e;
  ppn_t  w_ppn [2];
  logic  w_v   [2];
  logic  w_d   [2];
  mat_t  w_mat [2];
  plv_t  w_plv [2];

  // page-resolved fields from each entry
  logic [TLB_ENTRY_NUM-1:0] ent_match;
  logic [TLB_ENTRY_NUM-1:0] ent_huge;
  ppn_t ent_ppn [TLB_ENTRY_NUM];
  logic ent_v   [TLB_ENTRY_NUM];
  logic ent_d   [TLB_ENTRY_NUM];
  mat_t ent_mat [TLB_ENTRY_NUM];
  plv_t ent_plv [TLB_ENTRY_NUM];

  tlb_fill_ctrl u_fill_ctrl (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .fill_req_i (fill_req_i),
    .fill_idx_i (fill_idx_i),
    .key_vppn_i (fill_vppn_i),
    .key_asid_i (fill_asid_i),
    .key_g_i    (fill_g_i),
    .key_huge_i (fill_huge_i),
    .key_e_i    (fill_e_i),
    .val_ppn_i  (fill_ppn_i),
    .val_v_i    (fill_v_i),
    .val_d_i    (fill_d_i),
    .val_mat_i  (fill_mat_i),
    .val_plv_i  (fill_plv_i),
    .fill_ack_o (fill_ack_o),
    .we_o       (we),
    .key_vppn_o (w_vppn),
    .key_asid_o (w_asid),
    .key_g_o    (w_g),
    .key_huge_o (w_huge),
    .key_e_o    (w_e),
    .val_ppn_o  (w_ppn),
    .val_v_o    (w_v),
    .val_d_o    (w_d),
    .val_mat_o  (w_mat),
    .val_plv_o  (w_plv)
  );

  for (genvar i = 0; i < TLB_ENTRY_NUM; i++)
  begin : g_entry
    tlb_entry u_entry (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .we_i       (we[i]),
      .key_vppn_i (w_vppn),
      .key_asid_i (w_asid),
      .key_g_i    (w_g),
      .key_huge_i (w_huge),
      .key_e_i    (w_e),
      .val_ppn_i  (w_ppn),
      .val_v_i    (w_v),
      .val_d_i    (w_d),
      .val_mat_i  (w_mat),
      .val_plv_i  (w_plv),
      .vaddr_i    (vaddr_i),
      .asid_i     (asid_i),
      .match_o    (ent_match[i]),
      .huge_o     (ent_huge[i]),
      .ppn_o      (ent_ppn[i]),
      .v_o        (ent_v[i]),
      .d_o        (ent_d[i]),
      .mat_o      (ent_mat[i]),
      .plv_o      (ent_plv[i])
    );
  end

  trans_result_sel #(
    .FETCH_ADDR (FETCH_ADDR)
  ) u_result_sel (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .lookup_en_i (lookup_en_i),
    .vaddr_i     (vaddr_i),
    .crmd_i      (crmd_i),
    .dmw0_i      (dmw0_i),
    .dmw1_i      (dmw1_i),
    .match_i     (ent_match),
    .huge_i      (ent_huge),
    .ppn_i       (ent_ppn),
    .v_i         (ent_v),
    .d_i         (ent_d),
    .mat_i       (ent_mat),
    .plv_i       (ent_plv),
    .found_o     (found_o),
    .dmw_o       (dmw_o),
    .index_o     (index_o),
    .ps_o        (ps_o),
    .ppn_o       (ppn_o),
    .v_o         (v_o),
    .d_o         (d_o),
    .mat_o       (mat_o),
    .plv_o       (plv_o)
  );

endmodule

//--- logic/tlb_entry.sv
module tlb_entry
  import addr_trans_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  we_i,
  input  vppn_t key_vppn_i,
  input  asid_t key_asid_i,
  input  logic  key_g_i,
  input  logic  key_huge_i,
  input  logic  key_e_i,
  input  ppn_t  val_ppn_i [2],
  input  logic  val_v_i   [2],
  input  logic  val_d_i   [2],
  input  mat_t  val_mat_i [2],
  input  plv_t  val_plv_i [2],
  input  vaddr_t vaddr_i,
  input  asid_t asid_i,
  output logic  match_o,
  output logic  huge_o,
  output ppn_t  ppn_o,
  output logic  v_o,
  output logic  d_o,
  output mat_t  mat_o,
  output plv_t  plv_o
);

  vppn_t vppn_q;
  asid_t asid_q;
  logic  g_q;
  logic  huge_q;
  logic  e_q;
  ppn_t  ppn_q [2];
  logic  v_q   [2];
  logic  d_q   [2];
  mat_t  mat_q [2];
  plv_t  plv_q [2];
  logic  vppn_hit;
  logic  odd;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      e_q <= 1'b0;
    else if (we_i)
      e_q <= key_e_i;
  end

  always_ff @(posedge clk)
  begin
    if (we_i)
    begin
      vppn_q <= key_vppn_i;
      asid_q <= key_asid_i;
      g_q    <= key_g_i;
      huge_q <= key_huge_i;
      ppn_q  <= val_ppn_i;
      v_q    <= val_v_i;
      d_q    <= val_d_i;
      mat_q  <= val_mat_i;
      plv_q  <= val_plv_i;
    end
  end

  // a 4M pair spans 8M, so only vppn[18:10] takes part
  always_comb
  begin
    if (huge_q)
      vppn_hit = (vppn_q[18:10] == vaddr_i[31:23]);
    else
      vppn_hit = (vppn_q == vaddr_i[31:13]);
  end

  assign match_o = e_q && vppn_hit && (g_q || (asid_q == asid_i));

  // even or odd half of the pair
  assign odd = huge_q ? vaddr_i[22] : vaddr_i[12];

  assign huge_o = huge_q;
  assign ppn_o  = ppn_q[odd];
  assign v_o    = v_q[odd];
  assign d_o    = d_q[odd];
  assign mat_o  = mat_q[odd];
  assign plv_o  = plv_q[odd];

endmodule

//--- logic/tlb_fill_ctrl.sv
module tlb_fill_ctrl
  import addr_trans_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     fill_req_i,
  input  tlb_idx_t fill_idx_i,
  input  vppn_t    key_vppn_i,
  input  asid_t    key_asid_i,
  input  logic     key_g_i,
  input  logic     key_huge_i,
  input  logic     key_e_i,
  input  ppn_t     val_ppn_i [2],
  input  logic     val_v_i   [2],
  input  logic     val_d_i   [2],
  input  mat_t     val_mat_i [2],
  input  plv_t     val_plv_i [2],
  output logic     fill_ack_o,
  output logic [TLB_ENTRY_NUM-1:0] we_o,
  output vppn_t    key_vppn_o,
  output asid_t    key_asid_o,
  output logic     key_g_o,
  output logic     key_huge_o,
  output logic     key_e_o,
  output ppn_t     val_ppn_o [2],
  output logic     val_v_o   [2],
  output logic     val_d_o   [2],
  output mat_t     val_mat_o [2],
  output plv_t     val_plv_o [2]
);

  fill_state_t state_q;
  tlb_idx_t    idx_q;
  logic        ack_q;
  logic        accept;

  // a new request waits until the previous ack has dropped
  assign accept = (state_q == IDLE) && fill_req_i && !ack_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
    end
    else
    begin
      // ack trails the state by one cycle on both edges
      ack_q <= (state_q == ACK);
      case (state_q)
        IDLE:
        begin
          if (accept)
            state_q <= WRITE;
        end
        WRITE:
          state_q <= ACK;
        ACK:
        begin
          if (!fill_req_i)
            state_q <= IDLE;
        end
        default:
          state_q <= IDLE;
      endcase
    end
  end

  // capture request fields
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      idx_q      <= fill_idx_i;
      key_vppn_o <= key_vppn_i;
      key_asid_o <= key_asid_i;
      key_g_o    <= key_g_i;
      key_huge_o <= key_huge_i;
      key_e_o    <= key_e_i;
      val_ppn_o  <= val_ppn_i;
      val_v_o    <= val_v_i;
      val_d_o    <= val_d_i;
      val_mat_o  <= val_mat_i;
      val_plv_o  <= val_plv_i;
    end
  end

  // one strobe, only while in WRITE
  always_comb
  begin
    we_o = '0;
    if (state_q == WRITE)
      we_o[idx_q] = 1'b1;
  end

  assign fill_ack_o = ack_q;

endmodule

//--- logic/trans_result_sel.sv
module trans_result_sel
  import addr_trans_pkg::*;
#(
  parameter bit FETCH_ADDR = 1'b0
) (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        lookup_en_i,
  input  vaddr_t      vaddr_i,
  input  logic [31:0] crmd_i,
  input  logic [31:0] dmw0_i,
  input  logic [31:0] dmw1_i,
  input  logic [TLB_ENTRY_NUM-1:0] match_i,
  input  logic [TLB_ENTRY_NUM-1:0] huge_i,
  input  ppn_t        ppn_i [TLB_ENTRY_NUM],
  input  logic        v_i   [TLB_ENTRY_NUM],
  input  logic        d_i   [TLB_ENTRY_NUM],
  input  mat_t        mat_i [TLB_ENTRY_NUM],
  input  plv_t        plv_i [TLB_ENTRY_NUM],
  output logic        found_o,
  output logic        dmw_o,
  output tlb_idx_t    index_o,
  output ps_t         ps_o,
  output ppn_t        ppn_o,
  output logic        v_o,
  output logic        d_o,
  output mat_t        mat_o,
  output plv_t        plv_o
);

  plv_t        cur_plv;
  logic        dmw0_hit;
  logic        dmw1_hit;
  logic [31:0] dmw_sel;

  logic        tlb_found;
  logic        tlb_huge;
  tlb_idx_t    tlb_index;
  ppn_t        tlb_ppn;
  logic        tlb_v;
  logic        tlb_d;
  mat_t        tlb_mat;
  plv_t        tlb_plv;

  logic        res_found;
  logic        res_dmw;
  tlb_idx_t    res_index;
  ps_t         res_ps;
  ppn_t        res_ppn;
  logic        res_v;
  logic        res_d;
  mat_t        res_mat;
  plv_t        res_plv;

  // segment match, enabled for the current privilege level
  function automatic logic win_hit(logic [31:0] dmw, vaddr_t va, plv_t plv);
    return (va[31:29] == dmw[DMW_VSEG_LO +: 3]) &&
           ((dmw[DMW_PLV0] && (plv == 2'd0)) || (dmw[DMW_PLV3] && (plv == 2'd3)));
  endfunction

  assign cur_plv  = crmd_i[CRMD_PLV_LO +: 2];
  assign dmw0_hit = win_hit(dmw0_i, vaddr_i, cur_plv);
  assign dmw1_hit = win_hit(dmw1_i, vaddr_i, cur_plv);
  // window 0 takes priority
  assign dmw_sel  = dmw0_hit ? dmw0_i : dmw1_i;

  // hits are one-hot, so OR-ing the fields is enough
  always_comb
  begin
    tlb_found = |match_i;
    tlb_huge  = 1'b0;
    tlb_index = '0;
    tlb_ppn   = '0;
    tlb_v     = 1'b0;
    tlb_d     = 1'b0;
    tlb_mat   = '0;
    tlb_plv   = '0;
    for (int i = 0; i < TLB_ENTRY_NUM; i++)
    begin
      if (match_i[i])
      begin
        tlb_huge  |= huge_i[i];
        tlb_index |= tlb_idx_t'(i);
        tlb_ppn   |= ppn_i[i];
        tlb_v     |= v_i[i];
        tlb_d     |= d_i[i];
        tlb_mat   |= mat_i[i];
        tlb_plv   |= plv_i[i];
      end
    end
  end

  // direct address, then windows, then tlb
  always_comb
  begin
    res_found = 1'b1;
    res_dmw   = 1'b1;
    res_index = '0;
    res_ps    = PS_4K;
    res_v     = 1'b1;
    res_d     = 1'b1;
    if (crmd_i[CRMD_DA])
    begin
      res_ppn = vaddr_i[31:12];
      res_mat = FETCH_ADDR ? crmd_i[CRMD_DATF_LO +: 2] : crmd_i[CRMD_DATM_LO +: 2];
      res_plv = 2'd3;
    end
    else if (dmw0_hit || dmw1_hit)
    begin
      res_ppn = {dmw_sel[DMW_PSEG_LO +: 3], vaddr_i[28:12]};
      res_mat = dmw_sel[DMW_MAT_LO +: 2];
      res_plv = dmw_sel[DMW_PLV3] ? 2'd3 : 2'd0;
    end
    else
    begin
      // all zero on a miss
      res_found = tlb_found;
      res_dmw   = 1'b0;
      res_index = tlb_index;
      res_ps    = tlb_found ? (tlb_huge ? PS_4M : PS_4K) : '0;
      res_ppn   = tlb_ppn;
      res_v     = tlb_v;
      res_d     = tlb_d;
      res_mat   = tlb_mat;
      res_plv   = tlb_plv;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      found_o <= 1'b0;
      dmw_o   <= 1'b0;
    end
    else if (lookup_en_i)
    begin
      found_o <= res_found;
      dmw_o   <= res_dmw;
    end
  end

  // outputs hold while the pipeline stalls
  always_ff @(posedge clk)
  begin
    if (lookup_en_i)
    begin
      index_o <= res_index;
      ps_o    <= res_ps;
      ppn_o   <= res_ppn;
      v_o     <= res_v;
      d_o     <= res_d;
      mat_o   <= res_mat;
      plv_o   <= res_plv;
    end
  end

endmodule

//--- sim/addr_trans_props.sv
module addr_trans_props
  import addr_trans_pkg::*;
(
  input logic                     clk,
  input logic                     rst_n_i,
  input logic                     fill_req_i,
  input logic                     fill_ack_i,
  input logic [TLB_ENTRY_NUM-1:0] we_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // ack may only rise while the host still requests
  ack_rise_with_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(fill_ack_i) |-> $past(fill_req_i))
    else $error("fill ack rose without a pending request");

  ack_fall_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    $fell(fill_ack_i) |-> $past(!fill_req_i))
    else $error("fill ack fell before request was released");

  // at most one entry written per cycle
  we_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0(we_i))
    else $error("write strobes not one-hot");

endmodule

//--- sim/addr_trans_tb.sv
module addr_trans_tb
  import addr_trans_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RES_W        = 38;
  localparam int ACK_TIMEOUT  = 20;
  localparam int RAND_LOOKUPS = 40;
  localparam logic [31:0] SEED = 32'h3bd7_9759;

  logic        clk;
  logic        rst_n_i;
  logic        fill_req_i;
  tlb_idx_t    fill_idx_i;
  vppn_t       fill_vppn_i;
  asid_t       fill_asid_i;
  logic        fill_g_i;
  logic        fill_huge_i;
  logic        fill_e_i;
  ppn_t        fill_ppn_i [2];
  logic        fill_v_i   [2];
  logic        fill_d_i   [2];
  mat_t        fill_mat_i [2];
  plv_t        fill_plv_i [2];
  logic        fill_ack_o;
  logic        lookup_en_i;
  vaddr_t      vaddr_i;
  asid_t       asid_i;
  logic [31:0] crmd_i;
  logic [31:0] dmw0_i;
  logic [31:0] dmw1_i;
  logic        found_o;
  logic        dmw_o;
  tlb_idx_t    index_o;
  ps_t         ps_o;
  ppn_t        ppn_o;
  logic        v_o;
  logic        d_o;
  mat_t        mat_o;
  plv_t        plv_o;

  // shadow copy of every fill
  vppn_t sh_vppn [TLB_ENTRY_NUM];
  asid_t sh_asid [TLB_ENTRY_NUM];
  logic  sh_g    [TLB_ENTRY_NUM];
  logic  sh_huge [TLB_ENTRY_NUM];
  logic  sh_e    [TLB_ENTRY_NUM];
  ppn_t  sh_ppn  [TLB_ENTRY_NUM][2];
  logic  sh_v    [TLB_ENTRY_NUM][2];
  logic  sh_d    [TLB_ENTRY_NUM][2];
  mat_t  sh_mat  [TLB_ENTRY_NUM][2];
  plv_t  sh_plv  [TLB_ENTRY_NUM][2];

  logic [RES_W-1:0] exp_q [$];
  logic [RES_W-1:0] last_exp;
  logic [RES_W-1:0] got;
  logic             pending;
  logic             have_result;

  tb_clk_gen u_clk_gen (
    .clk_o (clk)
  );

  addr_trans_top #(
    .FETCH_ADDR (1'b0)
  ) DUT (.*);

  bind tlb_fill_ctrl addr_trans_props u_props (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .fill_req_i (fill_req_i),
    .fill_ack_i (fill_ack_o),
    .we_i       (we_o)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  function automatic logic window_hits(input logic [31:0] w, input vaddr_t va, input plv_t plv);
    return (w[31:29] == va[31:29]) && ((w[0] && plv == 2'd0) || (w[3] && plv == 2'd3));
  endfunction

  function automatic logic [31:0] make_window(input logic [2:0] vseg, input logic [2:0] pseg,
                                              input mat_t mat, input logic plv0,
                                              input logic plv3);
    logic [31:0] w;
    w        = '0;
    w[31:29] = vseg;
    w[27:25] = pseg;
    w[5:4]   = mat;
    w[3]     = plv3;
    w[0]     = plv0;
    return w;
  endfunction

  // expected {found, dmw, index, ps, ppn, v, d, mat, plv}
  function automatic logic [RES_W-1:0] ref_translate(input vaddr_t va, input asid_t asid,
                                                     input logic [31:0] crmd,
                                                     input logic [31:0] w0,
                                                     input logic [31:0] w1);
    plv_t        plv;
    logic [31:0] w;
    logic        odd;
    logic        key_ok;
    plv = crmd[1:0];
    if (crmd[3])
      return {2'b11, tlb_idx_t'(0), PS_4K, va[31:12], 2'b11, crmd[8:7], 2'd3};
    if (window_hits(w0, va, plv) || window_hits(w1, va, plv))
    begin
      w = window_hits(w0, va, plv) ? w0 : w1;
      return {2'b11, tlb_idx_t'(0), PS_4K, w[27:25], va[28:12], 2'b11, w[5:4],
              (w[3] ? 2'd3 : 2'd0)};
    end
    for (int k = 0; k < TLB_ENTRY_NUM; k++)
    begin
      if (sh_huge[k])
        key_ok = (sh_vppn[k][18:10] == va[31:23]);
      else
        key_ok = (sh_vppn[k] == va[31:13]);
      if (sh_e[k] && key_ok && (sh_g[k] || sh_asid[k] == asid))
      begin
        odd = sh_huge[k] ? va[22] : va[12];
        return {2'b10, tlb_idx_t'(k), (sh_huge[k] ? PS_4M : PS_4K), sh_ppn[k][odd],
                sh_v[k][odd], sh_d[k][odd], sh_mat[k][odd], sh_plv[k][odd]};
      end
    end
    return '0;
  endfunction

  // random page values, four-phase handshake
  task automatic fill_entry(input int idx, input vppn_t vppn, input asid_t asid,
                            input logic g, input logic huge);
    int cnt;
    lookup_en_i = 1'b0;
    fill_idx_i  = tlb_idx_t'(idx);
    fill_vppn_i = vppn;
    fill_asid_i = asid;
    fill_g_i    = g;
    fill_huge_i = huge;
    fill_e_i    = 1'b1;
    for (int h = 0; h < 2; h++)
    begin
      fill_ppn_i[h] = ppn_t'($urandom);
      fill_v_i[h]   = 1'($urandom);
      fill_d_i[h]   = 1'($urandom);
      fill_mat_i[h] = mat_t'($urandom);
      fill_plv_i[h] = plv_t'($urandom);
    end
    assert (fill_ack_o == 1'b0)
      else stop_on_error($sformatf("fill ack already high before request to entry %0d", idx));
    fill_req_i = 1'b1;
    cnt = 0;
    while (!fill_ack_o && cnt < ACK_TIMEOUT)
    begin
      @(negedge clk);
      cnt++;
    end
    if (!fill_ack_o)
      stop_on_error($sformatf("timeout waiting for fill ack to rise, entry %0d", idx));
    // two cycles after the sampling edge
    assert (cnt == 3)
      else stop_on_error($sformatf("Fail at %0t ns: fill ack after %0d cycles, expected 2",
                                   $time, cnt - 1));
    fill_req_i = 1'b0;
    cnt = 0;
    while (fill_ack_o && cnt < ACK_TIMEOUT)
    begin
      @(negedge clk);
      cnt++;
    end
    if (fill_ack_o)
      stop_on_error($sformatf("timeout waiting for fill ack to fall, entry %0d", idx));
    // one cycle after req is sampled low
    assert (cnt == 2)
      else stop_on_error($sformatf("Fail at %0t ns: fill ack fell after %0d cycles, expected 1",
                                   $time, cnt - 1));
    sh_vppn[idx] = vppn;
    sh_asid[idx] = asid;
    sh_g[idx]    = g;
    sh_huge[idx] = huge;
    sh_e[idx]    = 1'b1;
    for (int h = 0; h < 2; h++)
    begin
      sh_ppn[idx][h] = fill_ppn_i[h];
      sh_v[idx][h]   = fill_v_i[h];
      sh_d[idx][h]   = fill_d_i[h];
      sh_mat[idx][h] = fill_mat_i[h];
      sh_plv[idx][h] = fill_plv_i[h];
    end
  endtask

  task automatic lookup(input vaddr_t va, input asid_t asid);
    lookup_en_i = 1'b1;
    vaddr_i     = va;
    asid_i      = asid;
    exp_q.push_back(ref_translate(va, asid, crmd_i, dmw0_i, dmw1_i));
    @(negedge clk);
  endtask

  // pipeline stall, address keeps moving
  task automatic stall_cycles(input int n);
    lookup_en_i = 1'b0;
    repeat (n)
    begin
      vaddr_i = vaddr_t'($urandom);
      asid_i  = asid_t'($urandom);
      @(negedge clk);
    end
  endtask

  // result of an enabled lookup shows one edge later and holds until the next
  always @(posedge clk)
  begin
    if (rst_n_i)
    begin
      if (pending)
      begin
        last_exp    = exp_q.pop_front();
        have_result = 1'b1;
      end
      if (have_result)
      begin
        got = {found_o, dmw_o, index_o, ps_o, ppn_o, v_o, d_o, mat_o, plv_o};
        assert (got === last_exp)
          else stop_on_error($sformatf("Fail at %0t ns: result expected %h got %h",
                                       $time, last_exp, got));
      end
      pending = lookup_en_i;
    end
  end

  initial
  begin
    vppn_t      vppn;
    logic [2:0] vseg;
    void'($urandom(SEED));
    pending     = 1'b0;
    have_result = 1'b0;
    rst_n_i     = 1'b0;
    fill_req_i  = 1'b0;
    fill_idx_i  = '0;
    fill_vppn_i = '0;
    fill_asid_i = '0;
    fill_g_i    = 1'b0;
    fill_huge_i = 1'b0;
    fill_e_i    = 1'b0;
    for (int h = 0; h < 2; h++)
    begin
      fill_ppn_i[h] = '0;
      fill_v_i[h]   = 1'b0;
      fill_d_i[h]   = 1'b0;
      fill_mat_i[h] = '0;
      fill_plv_i[h] = '0;
    end
    lookup_en_i = 1'b0;
    vaddr_i     = '0;
    asid_i      = '0;
    crmd_i      = '0;
    dmw0_i      = '0;
    dmw1_i      = '0;
    for (int k = 0; k < TLB_ENTRY_NUM; k++)
      sh_e[k] = 1'b0;

    repeat (8) @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);
    assert (found_o == 1'b0 && dmw_o == 1'b0 && fill_ack_o == 1'b0)
      else stop_on_error($sformatf("Fail at %0t ns: outputs not cleared by reset", $time));

    // 4K entries live below 2G, index in the low key bits keeps them distinct
    for (int i = 0; i < TLB_ENTRY_NUM; i++)
    begin
      vppn = {1'b0, 14'($urandom), 4'(i)};
      fill_entry(i, vppn, asid_t'($urandom), (i % 4 == 0), 1'b0);
    end
    for (int k = 0; k < TLB_ENTRY_NUM; k++)
    begin
      lookup({sh_vppn[k], 1'b0, 12'($urandom)}, sh_asid[k]);
      lookup({sh_vppn[k], 1'b1, 12'($urandom)}, sh_asid[k]);
      lookup({sh_vppn[k], 1'b0, 12'($urandom)}, sh_asid[k] ^ asid_t'(1));
    end
    for (int n = 0; n < RAND_LOOKUPS; n++)
      lookup(vaddr_t'($urandom), asid_t'($urandom));

    // huge pages above 2G
    for (int i = 12; i < TLB_ENTRY_NUM; i++)
    begin
      vppn = {1'b1, 4'($urandom), 4'(i), 10'($urandom)};
      fill_entry(i, vppn, asid_t'($urandom), (i == 15), 1'b1);
    end
    for (int k = 12; k < TLB_ENTRY_NUM; k++)
    begin
      for (int n = 0; n < 6; n++)
        lookup({sh_vppn[k][18:10], 1'(n), 22'($urandom)}, sh_asid[k]);
      lookup({sh_vppn[k][18:10], 23'($urandom)}, sh_asid[k] ^ asid_t'(2));
    end
    for (int n = 0; n < RAND_LOOKUPS; n++)
      lookup({1'b1, 31'($urandom)}, asid_t'($urandom));

    // windows over the segment of entry 0
    vseg = sh_vppn[0][18:16];
    for (int c = 0; c < 9; c++)
    begin
      dmw0_i = make_window(vseg, 3'($urandom), mat_t'($urandom), 1'b1, c[0]);
      dmw1_i = make_window(vseg, 3'($urandom), mat_t'($urandom), c[1], 1'b1);
      crmd_i = '0;
      crmd_i[1:0] = (c == 8) ? 2'd1 : (c[2] ? 2'd3 : 2'd0);
      lookup({sh_vppn[0], 1'b0, 12'($urandom)}, sh_asid[0]);
      lookup({sh_vppn[0], 1'b1, 12'($urandom)}, sh_asid[0]);
      for (int k = 1; k < 12; k++)
        lookup({sh_vppn[k], 1'b0, 12'($urandom)}, sh_asid[k]);
      lookup({vseg, 29'($urandom)}, asid_t'($urandom));
      lookup({vseg, 29'($urandom)}, asid_t'($urandom));
    end

    // direct address overrides everything
    crmd_i      = '0;
    crmd_i[3]   = 1'b1;
    crmd_i[1:0] = 2'd0;
    crmd_i[8:7] = mat_t'($urandom);
    crmd_i[6:5] = ~crmd_i[8:7];
    for (int k = 0; k < TLB_ENTRY_NUM; k++)
      lookup({sh_vppn[k], 13'($urandom)}, sh_asid[k]);
    for (int n = 0; n < 20; n++)
      lookup(vaddr_t'($urandom), asid_t'($urandom));

    crmd_i = '0;
    dmw0_i = '0;
    dmw1_i = '0;
    lookup({sh_vppn[1], 1'b1, 12'($urandom)}, sh_asid[1]);
    stall_cycles(6);
    for (int k = 0; k < 8; k++)
      lookup({sh_vppn[k], 1'(k), 12'($urandom)}, sh_asid[k]);
    stall_cycles(3);

    $display("sim passed");
    $finish;
  end

endmodule

//--- sim/tb_clk_gen.sv
module tb_clk_gen
(
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam time HALF_PERIOD = 50ns;

  // free running, 100 ns period
  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #HALF_PERIOD;
      clk_o = ~clk_o;
    end
  end

endmodule

//--- verilog.f
logic/addr_trans_pkg.sv
logic/tlb_entry.sv
logic/tlb_fill_ctrl.sv
logic/trans_result_sel.sv
logic/addr_trans_top.sv
sim/tb_clk_gen.sv
sim/addr_trans_props.sv
sim/addr_trans_tb.sv
